// ==== tb.f ====
source/fetch_pkg.sv
source/fetch_icache.sv
source/fetch_predecode.sv
source/fetch_unit.sv
source/fetch_top.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = fetch_tb
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;

	import fetch_pkg::*;

	localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
	localparam int ICACHE_LINES = 16;
	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int NUM_INSTR = 1000;
	// A slow refill, busy cycles and a jump or interrupt wait stay well under 20 cycles
	localparam int CYCLE_LIMIT = NUM_INSTR * 20;

	logic i_clock, i_reset, i_jump, i_irq_pending, i_bus_ready, i_busy;
	logic [31:0] i_jump_pc, i_irq_pc, i_bus_rdata;
	logic o_irq_dispatched, o_bus_request, o_strobe;
	logic [31:0] o_irq_epc, o_bus_address, o_pc, o_instruction;
	register_t o_rs1, o_rs2, o_rd;

	logic [31:0] lcg_state = 32'd52660;
	fetch_state_t model_state;
	logic [31:0] exp_pc, exp_epc;
	logic model_last, exp_dispatch, prev_strobe, prev_request;
	logic [ICACHE_LINES-1:0] shadow_valid;
	logic [29-INDEX_BITS:0] shadow_tag [ICACHE_LINES];
	int bus_wait, jump_delay, irq_delay, cycles, checked, errors;

	fetch_top #(
		.RESET_VECTOR(RESET_VECTOR),
		.ICACHE_LINES(ICACHE_LINES)
	) uut (
		.i_clock(i_clock), .i_reset(i_reset), .i_jump(i_jump), .i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending), .i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched), .o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request), .o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata), .i_busy(i_busy),
		.o_strobe(o_strobe), .o_pc(o_pc), .o_instruction(o_instruction),
		.o_rs1(o_rs1), .o_rs2(o_rs2), .o_rd(o_rd)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {16'h0000, lcg_state[31:16]};
	endfunction

	function automatic logic [31:0] address_hash(input logic [31:0] addr);
		logic [31:0] h;
		h = addr * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		h = h * 32'h85EB_CA6B;
		return h ^ (h >> 13);
	endfunction

	// 0 ordinary, 1 control, 2 trap wait
	function automatic int program_class(input logic [31:0] addr);
		int pick;
		pick = int'(address_hash(addr) % 32'd100);
		if (pick < 80) begin
			return 0;
		end else if (pick < 92) begin
			return 1;
		end
		return 2;
	endfunction

	// Program memory contents, fixed per address
	function automatic logic [31:0] program_word(input logic [31:0] addr);
		logic [31:0] h;
		logic [31:0] f;
		h = address_hash(addr);
		f = address_hash(addr ^ 32'h5A5A_0000);
		case (program_class(addr))
			0:
				case (h[2:0])
					3'd0: return {f[31:7], opcode_op};
					3'd1: return {f[31:7], opcode_op_imm};
					3'd2: return {f[31:7], opcode_load};
					3'd3: return {f[31:7], opcode_store};
					3'd4: return {f[31:7], opcode_lui};
					3'd5: return {f[31:7], opcode_auipc};
					// CSR access, funct3 never zero
					default: return {f[31:15], f[14:13], 1'b1, f[11:7], opcode_system};
				endcase
			1:
				case (h[9:8])
					2'd0: return {f[31:7], opcode_branch};
					2'd1: return {f[31:7], opcode_jal};
					2'd2: return {f[31:7], opcode_jalr};
					default: return instr_mret;
				endcase
			default: return h[12] ? instr_wfi : instr_ecall;
		endcase
	endfunction

	// Packed as rs1, rs2, rd with absent fields zero
	function automatic logic [14:0] expected_registers(input logic [31:0] word);
		logic [6:0] op;
		logic csr;
		logic rs1_used;
		logic rs2_used;
		logic rd_used;
		op = word[6:0];
		csr = (op == opcode_system) && (word[14:12] != 3'b000);
		rs1_used = csr || (op inside {opcode_op, opcode_op_imm, opcode_load, opcode_jalr,
			opcode_store, opcode_branch});
		rs2_used = op inside {opcode_op, opcode_store, opcode_branch};
		rd_used = csr || (op inside {opcode_op, opcode_op_imm, opcode_load, opcode_jalr,
			opcode_lui, opcode_auipc, opcode_jal});
		return {rs1_used ? word[19:15] : 5'd0, rs2_used ? word[24:20] : 5'd0,
			rd_used ? word[11:7] : 5'd0};
	endfunction

	function automatic logic [31:0] window_address(input logic [31:0] r);
		return RESET_VECTOR + ((r % 32'd64) << 2);
	endfunction

	function automatic logic line_hit(input logic [31:0] addr);
		return shadow_valid[addr[INDEX_BITS+1:2]] &&
			(shadow_tag[addr[INDEX_BITS+1:2]] == addr[31:INDEX_BITS+2]);
	endfunction

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected === actual) else begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic confirm(input logic ok, input string what);
		assert (ok) else begin
			errors++;
			$display("Error: %s", what);
		end
	endtask

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	initial begin
		logic [31:0] acc_pc;
		logic rise;
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = RESET_VECTOR;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_busy = 1'b0;
		model_state = fetch_running;
		exp_pc = RESET_VECTOR;
		exp_epc = '0;
		model_last = 1'b0;
		prev_strobe = 1'b0;
		prev_request = 1'b0;
		shadow_valid = '0;
		bus_wait = 0;
		jump_delay = 0;
		irq_delay = 0;
		cycles = 0;
		checked = 0;
		errors = 0;
		repeat (16) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		while (checked < NUM_INSTR && cycles < CYCLE_LIMIT) begin
			@(posedge i_clock);
			#1;
			cycles++;
			exp_dispatch = 1'b0;
			// Inputs still hold the values seen at the edge
			if (o_bus_request && !prev_request) begin
				confirm(model_state == fetch_running, "bus request while fetch was parked");
				compare_value("bus address", exp_pc, o_bus_address);
				confirm(!line_hit(o_bus_address), "bus request for a line that already hits");
				bus_wait = int'(next_random() % 32'd4);
			end
			if (o_strobe != prev_strobe) begin
				acc_pc = exp_pc;
				confirm(!i_busy, "strobe toggled while busy was high");
				confirm(model_state == fetch_running, "instruction delivered during a wait");
				compare_value("fetch pc", acc_pc, o_pc);
				compare_value("instruction", program_word(acc_pc), o_instruction);
				compare_value("register indices", 32'(expected_registers(program_word(acc_pc))),
					32'({o_rs1, o_rs2, o_rd}));
				checked++;
				exp_pc = acc_pc + 32'd4;
				case (program_class(acc_pc))
					1: begin
						model_state = fetch_wait_jump;
						jump_delay = int'(next_random() % 32'd4);
					end
					2: begin
						model_state = fetch_wait_irq;
						irq_delay = 1 + int'(next_random() % 32'd4);
					end
					default: begin
						rise = i_irq_pending && !model_last;
						model_last = i_irq_pending;
						if (rise) begin
							exp_dispatch = 1'b1;
							exp_epc = acc_pc + 32'd4;
							exp_pc = i_irq_pc;
						end
					end
				endcase
			end else if (model_state == fetch_wait_jump && i_jump) begin
				exp_pc = i_jump_pc;
				model_state = fetch_running;
			end else if (model_state == fetch_wait_irq) begin
				rise = i_irq_pending && !model_last;
				model_last = i_irq_pending;
				if (rise) begin
					exp_dispatch = 1'b1;
					exp_epc = exp_pc;
					exp_pc = i_irq_pc;
					model_state = fetch_running;
				end
			end
			compare_value("irq dispatched", 32'(exp_dispatch), 32'(o_irq_dispatched));
			if (exp_dispatch) begin
				compare_value("irq epc", exp_epc, o_irq_epc);
			end
			prev_strobe = o_strobe;
			prev_request = o_bus_request;

			// Memory answers after 0 to 3 cycles
			if (i_bus_ready) begin
				i_bus_ready = 1'b0;
			end else if (o_bus_request) begin
				if (bus_wait == 0) begin
					i_bus_ready = 1'b1;
					i_bus_rdata = program_word(o_bus_address);
					shadow_valid[o_bus_address[INDEX_BITS+1:2]] = 1'b1;
					shadow_tag[o_bus_address[INDEX_BITS+1:2]] = o_bus_address[31:INDEX_BITS+2];
				end else begin
					bus_wait--;
				end
			end

			// Execute stage resolves control transfers
			if (i_jump) begin
				i_jump = 1'b0;
			end else if (model_state == fetch_wait_jump) begin
				if (jump_delay == 0) begin
					i_jump = 1'b1;
					i_jump_pc = window_address(next_random());
				end else begin
					jump_delay--;
				end
			end

			// Trap waits get a clean low then high on pending
			if (model_state == fetch_wait_irq) begin
				if (irq_delay == 0) begin
					i_irq_pending = 1'b1;
					i_irq_pc = window_address(next_random());
				end else begin
					i_irq_pending = 1'b0;
					irq_delay--;
				end
			end else if (next_random() % 32'd32 == 32'd0) begin
				i_irq_pending = !i_irq_pending;
				i_irq_pc = window_address(next_random());
			end
			i_busy = (next_random() % 32'd5 == 32'd0);
		end
		if (checked < NUM_INSTR) begin
			errors++;
			$display("Error: cycle limit %0d reached after %0d instructions", CYCLE_LIMIT, checked);
		end
		$display("Summary: %0d instructions, %0d cycles, %0d errors", checked, cycles, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== dv/fetch_assertions.sv ====
`timescale 1ns/10ps

module fetch_assertions (
	input logic                    i_clock,
	input logic                    i_reset,
	input logic                    i_bus_request,
	input logic [31:0]             i_bus_address,
	input logic                    i_bus_ready,
	input logic                    i_irq_dispatched,
	input logic                    i_strobe,
	input fetch_pkg::fetch_state_t i_state
);

	import fetch_pkg::*;

	// Request and address held until the memory answers
	bus_request_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_address)
	) else $error("bus request or address changed before ready");

	dispatch_single_cycle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |=> !i_irq_dispatched
	) else $error("irq dispatch pulse lasted more than one cycle");

	// Nothing is accepted while a jump is outstanding
	no_strobe_in_jump_wait: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_state == fetch_wait_jump |=> $stable(i_strobe)
	) else $error("strobe toggled while waiting for a jump");

endmodule

bind fetch_unit fetch_assertions u_assertions (
	.i_clock          (i_clock),
	.i_reset          (i_reset),
	.i_bus_request    (o_bus_request),
	.i_bus_address    (o_bus_address),
	.i_bus_ready      (i_bus_ready),
	.i_irq_dispatched (o_irq_dispatched),
	.i_strobe         (o_strobe),
	.i_state          (state)
);

// ==== source/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_1000,
	parameter int          ICACHE_LINES = 16
) (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_jump,
	input  logic [31:0]          i_jump_pc,
	input  logic                 i_irq_pending,
	input  logic [31:0]          i_irq_pc,
	output logic                 o_irq_dispatched,
	output logic [31:0]          o_irq_epc,
	output logic                 o_bus_request,
	output logic [31:0]          o_bus_address,
	input  logic                 i_bus_ready,
	input  logic [31:0]          i_bus_rdata,
	input  logic                 i_busy,
	output logic                 o_strobe,
	output logic [31:0]          o_pc,
	output logic [31:0]          o_instruction,
	output fetch_pkg::register_t o_rs1,
	output fetch_pkg::register_t o_rs2,
	output fetch_pkg::register_t o_rd
);

	// Subsystem configuration is fixed here
	fetch_unit #(
		.RESET_VECTOR(RESET_VECTOR),
		.ICACHE_LINES(ICACHE_LINES)
	) u_fetch (
		.i_clock          (i_clock),
		.i_reset          (i_reset),
		.i_jump           (i_jump),
		.i_jump_pc        (i_jump_pc),
		.i_irq_pending    (i_irq_pending),
		.i_irq_pc         (i_irq_pc),
		.o_irq_dispatched (o_irq_dispatched),
		.o_irq_epc        (o_irq_epc),
		.o_bus_request    (o_bus_request),
		.o_bus_address    (o_bus_address),
		.i_bus_ready      (i_bus_ready),
		.i_bus_rdata      (i_bus_rdata),
		.i_busy           (i_busy),
		.o_strobe         (o_strobe),
		.o_pc             (o_pc),
		.o_instruction    (o_instruction),
		.o_rs1            (o_rs1),
		.o_rs2            (o_rs2),
		.o_rd             (o_rd)
	);

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_1000,
	parameter int          ICACHE_LINES = 16
) (
	input  logic                 i_clock,
	input  logic                 i_reset,

	// Control from execute
	input  logic                 i_jump,
	input  logic [31:0]          i_jump_pc,

	// Interrupt
	input  logic                 i_irq_pending,
	input  logic [31:0]          i_irq_pc,
	output logic                 o_irq_dispatched,
	output logic [31:0]          o_irq_epc,

	// Memory bus
	output logic                 o_bus_request,
	output logic [31:0]          o_bus_address,
	input  logic                 i_bus_ready,
	input  logic [31:0]          i_bus_rdata,

	// Output to decode
	input  logic                 i_busy,
	output logic                 o_strobe,
	output logic [31:0]          o_pc,
	output logic [31:0]          o_instruction,
	output fetch_pkg::register_t o_rs1,
	output fetch_pkg::register_t o_rs2,
	output fetch_pkg::register_t o_rd
);

	import fetch_pkg::*;

	fetch_state_t state;
	logic [31:0]  pc;
	logic [31:0]  pc_next;
	logic         last_pending;

	logic [31:0] icache_rdata;
	logic        icache_ready;
	logic        icache_stall;

	register_t pre_rs1;
	register_t pre_rs2;
	register_t pre_rd;
	logic      pre_is_control;
	logic      pre_is_trap_wait;

	logic accept;
	logic ordinary;
	logic irq_rise;
	logic dispatch_ordinary;
	logic dispatch_wait;

	fetch_icache #(
		.ICACHE_LINES(ICACHE_LINES)
	) u_icache (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_pc          (pc),
		.i_stall       (icache_stall),
		.o_rdata       (icache_rdata),
		.o_ready       (icache_ready),
		.o_bus_request (o_bus_request),
		.o_bus_address (o_bus_address),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata)
	);

	fetch_predecode u_predecode (
		.i_instruction  (icache_rdata),
		.o_rs1          (pre_rs1),
		.o_rs2          (pre_rs2),
		.o_rd           (pre_rd),
		.o_is_control   (pre_is_control),
		.o_is_trap_wait (pre_is_trap_wait)
	);

	assign icache_stall = i_busy || (state != fetch_running);
	assign pc_next = pc + 32'd4;

	// Cache ready already folds in the stall, so this implies fetch_running
	assign accept   = icache_ready;
	assign ordinary = accept && !pre_is_control && !pre_is_trap_wait;
	assign irq_rise = i_irq_pending && !last_pending;

	assign dispatch_ordinary = ordinary && irq_rise;
	assign dispatch_wait     = (state == fetch_wait_irq) && irq_rise;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state            <= fetch_running;
			pc               <= RESET_VECTOR;
			last_pending     <= 1'b0;
			o_strobe         <= 1'b0;
			o_irq_dispatched <= 1'b0;
		end else begin
			o_irq_dispatched <= dispatch_ordinary || dispatch_wait;
			case (state)
				fetch_running: begin
					if (accept) begin
						o_strobe <= ~o_strobe;
						pc       <= pc_next;
						if (pre_is_control) begin
							state <= fetch_wait_jump;
						end else if (pre_is_trap_wait) begin
							state <= fetch_wait_irq;
						end else begin
							// Safe point between ordinary instructions
							last_pending <= i_irq_pending;
							if (irq_rise) begin
								pc <= i_irq_pc;
							end
						end
					end
				end
				fetch_wait_jump: begin
					if (i_jump) begin
						pc    <= i_jump_pc;
						state <= fetch_running;
					end
				end
				fetch_wait_irq: begin
					last_pending <= i_irq_pending;
					if (irq_rise) begin
						pc    <= i_irq_pc;
						state <= fetch_running;
					end
				end
				default: begin
					state <= fetch_running;
				end
			endcase
		end
	end

	// Output payload, stable between strobe toggles
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_pc          <= pc;
			o_instruction <= icache_rdata;
			o_rs1         <= pre_rs1;
			o_rs2         <= pre_rs2;
			o_rd          <= pre_rd;
		end
	end

	// PC already points past the trap while waiting
	always_ff @(posedge i_clock) begin
		if (dispatch_ordinary) begin
			o_irq_epc <= pc_next;
		end else if (dispatch_wait) begin
			o_irq_epc <= pc;
		end
	end

endmodule

// ==== source/fetch_predecode.sv ====
`timescale 1ns/10ps

module fetch_predecode (
	input  logic [31:0]          i_instruction,
	output fetch_pkg::register_t o_rs1,
	output fetch_pkg::register_t o_rs2,
	output fetch_pkg::register_t o_rd,
	output logic                 o_is_control,
	output logic                 o_is_trap_wait
);

	import fetch_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;

	// Format classes
	logic is_r;
	logic is_i;
	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;
	logic is_csr;

	logic have_rs1;
	logic have_rs2;
	logic have_rd;

	assign opcode = i_instruction[6:0];
	assign funct3 = i_instruction[14:12];

	always_comb begin
		is_r = (opcode == opcode_op);
		is_i = (opcode == opcode_op_imm) || (opcode == opcode_load) ||
			(opcode == opcode_jalr);
		is_s = (opcode == opcode_store);
		is_b = (opcode == opcode_branch);
		is_u = (opcode == opcode_lui) || (opcode == opcode_auipc);
		is_j = (opcode == opcode_jal);
		// ECALL, WFI and MRET have funct3 zero and carry no registers
		is_csr = (opcode == opcode_system) && (funct3 != 3'b000);
	end

	always_comb begin
		have_rs1 = is_r || is_i || is_s || is_b || is_csr;
		have_rs2 = is_r || is_s || is_b;
		have_rd  = is_r || is_i || is_u || is_j || is_csr;
	end

	// Early register indices so the register file read can start
	always_comb begin
		o_rs1 = have_rs1 ? register_t'(i_instruction[19:15]) : register_t'(0);
		o_rs2 = have_rs2 ? register_t'(i_instruction[24:20]) : register_t'(0);
		o_rd  = have_rd  ? register_t'(i_instruction[11:7])  : register_t'(0);
	end

	// Anything that needs the execute stage to supply the next PC
	always_comb begin
		o_is_control = is_b || is_j || (opcode == opcode_jalr) ||
			(i_instruction == instr_mret);
	end

	// Fetch parks until an interrupt arrives
	always_comb begin
		o_is_trap_wait = (i_instruction == instr_ecall) ||
			(i_instruction == instr_wfi);
	end

endmodule

// ==== source/fetch_icache.sv ====
`timescale 1ns/10ps

module fetch_icache #(
	parameter int ICACHE_LINES = 16
) (
	input  logic        i_clock,
	input  logic        i_reset,

	// Lookup
	input  logic [31:0] i_pc,
	input  logic        i_stall,
	output logic [31:0] o_rdata,
	output logic        o_ready,

	// Memory bus
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic {
		refill_idle,
		refill_busy
	} refill_state_t;

	refill_state_t refill_state;

	// One word per line
	logic [31:0]         data_array [ICACHE_LINES];
	logic [TAG_BITS-1:0] tag_array  [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] line_valid;

	logic [INDEX_BITS-1:0] lookup_index;
	logic [TAG_BITS-1:0]   lookup_tag;
	logic                  lookup_hit;

	// Line being filled comes from the held bus address
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0]   fill_tag;

	assign lookup_index = i_pc[INDEX_BITS+1:2];
	assign lookup_tag   = i_pc[31:INDEX_BITS+2];
	assign fill_index   = o_bus_address[INDEX_BITS+1:2];
	assign fill_tag     = o_bus_address[31:INDEX_BITS+2];

	always_comb begin
		lookup_hit = line_valid[lookup_index] && (tag_array[lookup_index] == lookup_tag);
	end

	assign o_rdata = data_array[lookup_index];
	assign o_ready = lookup_hit && !i_stall;

	// Refill controller, request held until the bus answers
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			refill_state  <= refill_idle;
			o_bus_request <= 1'b0;
			line_valid    <= '0;
		end else begin
			case (refill_state)
				refill_idle: begin
					if (!lookup_hit && !i_stall) begin
						o_bus_request <= 1'b1;
						refill_state  <= refill_busy;
					end
				end
				refill_busy: begin
					// Completes even if a stall shows up meanwhile
					if (i_bus_ready) begin
						o_bus_request          <= 1'b0;
						line_valid[fill_index] <= 1'b1;
						refill_state           <= refill_idle;
					end
				end
				default: begin
					o_bus_request <= 1'b0;
					refill_state  <= refill_idle;
				end
			endcase
		end
	end

	// Address is captured when the miss starts
	always_ff @(posedge i_clock) begin
		if (refill_state == refill_idle && !lookup_hit && !i_stall) begin
			o_bus_address <= {i_pc[31:2], 2'b00};
		end
	end

	// Line write on the ready cycle
	always_ff @(posedge i_clock) begin
		if (refill_state == refill_busy && i_bus_ready) begin
			data_array[fill_index] <= i_bus_rdata;
			tag_array[fill_index]  <= fill_tag;
		end
	end

endmodule

// ==== source/fetch_pkg.sv ====
package fetch_pkg;

	// Register file index
	typedef logic [4:0] register_t;

	// Fetch controller states
	typedef enum logic [1:0] {
		fetch_running   = 2'd0,
		fetch_wait_jump = 2'd1,
		fetch_wait_irq  = 2'd2
	} fetch_state_t;

	// Base opcodes, instruction bits [6:0]
	localparam logic [6:0] opcode_op     = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;
	localparam logic [6:0] opcode_load   = 7'b0000011;
	localparam logic [6:0] opcode_store  = 7'b0100011;
	localparam logic [6:0] opcode_branch = 7'b1100011;
	localparam logic [6:0] opcode_lui    = 7'b0110111;
	localparam logic [6:0] opcode_auipc  = 7'b0010111;
	localparam logic [6:0] opcode_jal    = 7'b1101111;
	localparam logic [6:0] opcode_jalr   = 7'b1100111;
	localparam logic [6:0] opcode_system = 7'b1110011;

	// Exact encodings of the privileged system words
	localparam logic [31:0] instr_ecall = 32'h0000_0073;
	localparam logic [31:0] instr_wfi   = 32'h1050_0073;
	localparam logic [31:0] instr_mret  = 32'h3020_0073;

endpackage
